//--- src/apb_pkg.sv
// APB bus types shared by the timer peripheral and its testbench.
// Import where the request or response structs are needed.
`default_nettype none

package apb_pkg;

   localparam int unsigned APB_ADDR_W = 12;  // peripheral byte address space
   localparam int unsigned APB_DATA_W = 32;

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;

   // driven by the master
   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   // driven by the slave
   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire

//--- src/timer_pkg.sv
// Widths, channel configuration and register map of the two-channel timer.
// Used by every timer module and by the testbench.
`default_nettype none

package timer_pkg;

   localparam int unsigned COUNT_W  = 32;
   localparam int unsigned PRESC_W  = 8;
   localparam int unsigned NUM_CHAN = 2;
   localparam int unsigned CHAN_LO  = 0;
   localparam int unsigned CHAN_HI  = 1;

   typedef logic [COUNT_W-1:0]         count_t;
   typedef logic [PRESC_W-1:0]         presc_t;
   typedef logic [$clog2(NUM_CHAN)-1:0] chan_idx_t;

   typedef struct packed {
      logic   enable;
      logic   one_shot;  // drop enable at compare
      logic   presc_en;  // 0 bypasses the prescaler
      presc_t presc;
   } chan_cfg_t;

   // address map, one block of registers per channel
   localparam int unsigned CHAN_STRIDE = 'h10;
   localparam int unsigned CHAN_OFFS_W = $clog2(CHAN_STRIDE);

   typedef logic [CHAN_OFFS_W-1:0] reg_offs_t;

   localparam reg_offs_t REG_CFG = 'h0;
   localparam reg_offs_t REG_CNT = 'h4;
   localparam reg_offs_t REG_CMP = 'h8;

   // CFG word layout
   localparam int unsigned CFG_EN_BIT       = 0;
   localparam int unsigned CFG_ONE_SHOT_BIT = 1;
   localparam int unsigned CFG_PRESC_EN_BIT = 2;
   localparam int unsigned CFG_PRESC_LSB    = 8;
   localparam int unsigned CFG_RESET_BIT    = 31;  // write only, self clearing

endpackage

`default_nettype wire

//--- src/timer_prescaler.sv
// Per-channel prescaler: turns enabled bus clock cycles into count ticks.
// Ticks every cycle when bypassed, else once every presc+1 cycles.
`default_nettype none

module timer_prescaler
   import timer_pkg::*;
(
   input  logic      hclk_i,
   input  logic      rst_i,
   input  chan_cfg_t cfg_i,
   input  logic      restart_i,  // count load or reset from the bus
   output logic      tick_o
);

   presc_t phase_q;
   logic   phase_wrap;

   // bypass ticks on every cycle
   assign phase_wrap = !cfg_i.presc_en || (phase_q == cfg_i.presc);
   assign tick_o     = cfg_i.enable && phase_wrap;

   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         phase_q <= '0;
      end else if (restart_i || !cfg_i.enable) begin
         phase_q <= '0;  // next run starts on a fresh phase
      end else if (tick_o) begin
         phase_q <= '0;
      end else begin
         phase_q <= phase_q + presc_t'(1);
      end
   end

endmodule

`default_nettype wire

//--- src/timer_counter.sv
// Per-channel 32-bit up-counter with compare.
// Wraps to 0 on the tick that finds the count at compare and flags the match
// for that one cycle. Clear beats load, load beats tick.
`default_nettype none

module timer_counter
   import timer_pkg::*;
(
   input  logic   hclk_i,
   input  logic   rst_i,
   input  logic   tick_i,
   input  logic   load_i,
   input  count_t load_value_i,
   input  logic   clear_i,
   input  count_t compare_i,
   output count_t count_o,
   output logic   target_reached_o
);

   count_t count_q;
   logic   at_target;
   logic   bus_override;  // software access owns this cycle

   assign at_target    = (count_q == compare_i);
   assign bus_override = clear_i || load_i;

   // match only counts when the tick is actually taken
   assign target_reached_o = tick_i && at_target && !bus_override;

   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (clear_i) begin
         count_q <= '0;
      end else if (load_i) begin
         count_q <= load_value_i;
      end else if (tick_i) begin
         if (at_target) begin
            count_q <= '0;
         end else begin
            count_q <= count_q + count_t'(1);
         end
      end
   end

   assign count_o = count_q;

endmodule

`default_nettype wire

//--- src/timer_regs.sv
// APB slave of the timer: CFG, CNT and CMP per channel, zero wait states.
// CNT writes and the CFG reset bit leave as one-cycle strobes to the counters;
// one-shot channels lose their enable on the compare match.
`default_nettype none

module timer_regs
   import apb_pkg::*;
   import timer_pkg::*;
(
   input  logic      hclk_i,
   input  logic      rst_i,
   input  apb_req_t  apb_req_i,
   output apb_rsp_t  apb_rsp_o,
   input  logic      target_reached_i [NUM_CHAN],
   input  count_t    count_i          [NUM_CHAN],
   output chan_cfg_t cfg_o            [NUM_CHAN],
   output count_t    compare_o        [NUM_CHAN],
   output logic      load_o           [NUM_CHAN],
   output count_t    load_value_o,
   output logic      clear_o          [NUM_CHAN]
);

   // paddr bits above the register offset select the channel
   localparam int unsigned CHAN_FIELD_W = APB_ADDR_W - CHAN_OFFS_W;

   chan_cfg_t cfg_q [NUM_CHAN];
   count_t    cmp_q [NUM_CHAN];

   logic [CHAN_FIELD_W-1:0] chan_field;
   chan_idx_t               chan;
   reg_offs_t               offset;
   logic                    chan_hit;
   logic                    reg_hit;
   logic                    access;
   logic                    wr_en;

   function automatic apb_data_t cfg_to_word(chan_cfg_t cfg);
      apb_data_t word;
      word = '0;
      word[CFG_EN_BIT]               = cfg.enable;
      word[CFG_ONE_SHOT_BIT]         = cfg.one_shot;
      word[CFG_PRESC_EN_BIT]         = cfg.presc_en;
      word[CFG_PRESC_LSB +: PRESC_W] = cfg.presc;
      return word;
   endfunction

   function automatic chan_cfg_t word_to_cfg(apb_data_t word);
      chan_cfg_t cfg;
      cfg.enable   = word[CFG_EN_BIT];
      cfg.one_shot = word[CFG_ONE_SHOT_BIT];
      cfg.presc_en = word[CFG_PRESC_EN_BIT];
      cfg.presc    = word[CFG_PRESC_LSB +: PRESC_W];
      return cfg;
   endfunction

   // address decode
   assign chan_field = apb_req_i.paddr[APB_ADDR_W-1:CHAN_OFFS_W];
   assign chan       = chan_field[$bits(chan_idx_t)-1:0];
   assign offset     = apb_req_i.paddr[CHAN_OFFS_W-1:0];
   assign chan_hit   = (chan_field < CHAN_FIELD_W'(NUM_CHAN));
   assign reg_hit    = chan_hit &&
                       (offset == REG_CFG || offset == REG_CNT || offset == REG_CMP);

   assign access = apb_req_i.psel && apb_req_i.penable;
   assign wr_en  = access && apb_req_i.pwrite && reg_hit;

   always_comb begin
      apb_rsp_o.pready  = access;
      apb_rsp_o.pslverr = access && !reg_hit;
      apb_rsp_o.prdata  = '0;  // unmapped reads return 0
      if (reg_hit) begin
         case (offset)
            REG_CFG: apb_rsp_o.prdata = cfg_to_word(cfg_q[chan]);
            REG_CNT: apb_rsp_o.prdata = count_i[chan];
            REG_CMP: apb_rsp_o.prdata = cmp_q[chan];
            default: apb_rsp_o.prdata = '0;
         endcase
      end
   end

   // strobes act on the edge that ends the access phase
   always_comb begin
      for (int c = 0; c < NUM_CHAN; c++) begin
         load_o[c]  = wr_en && (chan == chan_idx_t'(c)) && (offset == REG_CNT);
         clear_o[c] = wr_en && (chan == chan_idx_t'(c)) && (offset == REG_CFG) &&
                      apb_req_i.pwdata[CFG_RESET_BIT];
      end
   end

   assign load_value_o = apb_req_i.pwdata;

   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            cfg_q[c] <= '0;
            cmp_q[c] <= '0;
         end
      end else begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            if (target_reached_i[c] && cfg_q[c].one_shot) begin
               cfg_q[c].enable <= 1'b0;  // one shot done
            end
         end
         // a bus write in the same cycle wins over the one-shot stop
         if (wr_en) begin
            case (offset)
               REG_CFG: cfg_q[chan] <= word_to_cfg(apb_req_i.pwdata);
               REG_CMP: cmp_q[chan] <= apb_req_i.pwdata;
               default: ;  // CNT lives in the counter
            endcase
         end
      end
   end

   always_comb begin
      for (int c = 0; c < NUM_CHAN; c++) begin
         cfg_o[c]     = cfg_q[c];
         compare_o[c] = cmp_q[c];
      end
   end

endmodule

`default_nettype wire

//--- src/timer_unit.sv
// Two-channel APB timer, lo and hi, each a prescaler feeding a counter.
// Each channel raises a one-cycle interrupt on its compare match.
`default_nettype none

module timer_unit
   import apb_pkg::*;
   import timer_pkg::*;
(
   input  logic     hclk_i,
   input  logic     rst_i,
   input  apb_req_t apb_req_i,
   output apb_rsp_t apb_rsp_o,
   output logic     irq_lo_o,
   output logic     irq_hi_o
);

   chan_cfg_t cfg            [NUM_CHAN];
   count_t    compare        [NUM_CHAN];
   count_t    count          [NUM_CHAN];
   logic      load           [NUM_CHAN];
   logic      clear          [NUM_CHAN];
   logic      restart        [NUM_CHAN];
   logic      tick           [NUM_CHAN];
   logic      target_reached [NUM_CHAN];
   count_t    load_value;  // shared, only one channel loads at a time

   timer_regs u_regs (
      .hclk_i           (hclk_i),
      .rst_i            (rst_i),
      .apb_req_i        (apb_req_i),
      .apb_rsp_o        (apb_rsp_o),
      .target_reached_i (target_reached),
      .count_i          (count),
      .cfg_o            (cfg),
      .compare_o        (compare),
      .load_o           (load),
      .load_value_o     (load_value),
      .clear_o          (clear)
   );

   // any software write to the count restarts the prescaler phase
   always_comb begin
      for (int c = 0; c < NUM_CHAN; c++) begin
         restart[c] = load[c] || clear[c];
      end
   end

   timer_prescaler u_presc_lo (
      .hclk_i    (hclk_i),
      .rst_i     (rst_i),
      .cfg_i     (cfg[CHAN_LO]),
      .restart_i (restart[CHAN_LO]),
      .tick_o    (tick[CHAN_LO])
   );

   timer_prescaler u_presc_hi (
      .hclk_i    (hclk_i),
      .rst_i     (rst_i),
      .cfg_i     (cfg[CHAN_HI]),
      .restart_i (restart[CHAN_HI]),
      .tick_o    (tick[CHAN_HI])
   );

   timer_counter u_cnt_lo (
      .hclk_i           (hclk_i),
      .rst_i            (rst_i),
      .tick_i           (tick[CHAN_LO]),
      .load_i           (load[CHAN_LO]),
      .load_value_i     (load_value),
      .clear_i          (clear[CHAN_LO]),
      .compare_i        (compare[CHAN_LO]),
      .count_o          (count[CHAN_LO]),
      .target_reached_o (target_reached[CHAN_LO])
   );

   timer_counter u_cnt_hi (
      .hclk_i           (hclk_i),
      .rst_i            (rst_i),
      .tick_i           (tick[CHAN_HI]),
      .load_i           (load[CHAN_HI]),
      .load_value_i     (load_value),
      .clear_i          (clear[CHAN_HI]),
      .compare_i        (compare[CHAN_HI]),
      .count_o          (count[CHAN_HI]),
      .target_reached_o (target_reached[CHAN_HI])
   );

   assign irq_lo_o = target_reached[CHAN_LO];
   assign irq_hi_o = target_reached[CHAN_HI];

endmodule

`default_nettype wire

//--- verification/timer_unit_assert.sv
// Bus and interrupt rules of the timer bound onto the timer_unit top level.
// Zero wait states, pslverr only with pready and one-cycle interrupt pulses.
`default_nettype none

module timer_unit_assert
   import apb_pkg::*;
(
   input logic     hclk_i,
   input logic     rst_i,
   input apb_req_t apb_req_i,
   input apb_rsp_t apb_rsp_i,
   input logic     irq_lo_i,
   input logic     irq_hi_i
);

   int unsigned fail_count = 0;

   a_pready_access : assert property (@(posedge hclk_i) disable iff (rst_i)
      apb_rsp_i.pready == (apb_req_i.psel && apb_req_i.penable))
   else begin
      fail_count++;
      $error("pready does not follow the APB access phase");
   end

   a_slverr_ready : assert property (@(posedge hclk_i) disable iff (rst_i)
      apb_rsp_i.pslverr |-> apb_rsp_i.pready)
   else begin
      fail_count++;
      $error("pslverr raised without pready");
   end

   // pulses stay single as long as compare is not 0 in bypass
   a_irq_lo_pulse : assert property (@(posedge hclk_i) disable iff (rst_i)
      irq_lo_i |=> !irq_lo_i)
   else begin
      fail_count++;
      $error("lo interrupt held for more than one cycle");
   end

   a_irq_hi_pulse : assert property (@(posedge hclk_i) disable iff (rst_i)
      irq_hi_i |=> !irq_hi_i)
   else begin
      fail_count++;
      $error("hi interrupt held for more than one cycle");
   end

endmodule

bind timer_unit timer_unit_assert u_timer_unit_assert (
   .hclk_i    (hclk_i),
   .rst_i     (rst_i),
   .apb_req_i (apb_req_i),
   .apb_rsp_i (apb_rsp_o),
   .irq_lo_i  (irq_lo_o),
   .irq_hi_i  (irq_hi_o)
);

`default_nettype wire

//--- verification/tb_timer_unit.sv
// Testbench for the two-channel APB timer. Checks register access, the error
// response and continuous, one-shot and count-reset timing against a reference model.
`default_nettype none

module tb_timer_unit
   import apb_pkg::*;
   import timer_pkg::*;
();

   localparam int unsigned CLK_PERIOD   = 40;
   localparam int unsigned RESET_CYCLES = 4;
   localparam int unsigned ACC_CYCLES   = 3;      // setup, access, idle
   localparam int unsigned MAX_P_CONT   = 9 * 8;  // compare and divide both up to 8
   localparam int unsigned MAX_P_SHOT   = 16;
   localparam int unsigned TEST_CYCLES  = 12 * ACC_CYCLES + 16 * ACC_CYCLES +
                                          4 * ACC_CYCLES + 3 * MAX_P_CONT +
                                          5 * ACC_CYCLES + 3 * MAX_P_SHOT +
                                          7 * ACC_CYCLES + 3 * MAX_P_CONT;
   localparam int unsigned TIMEOUT_CYCLES = (RESET_CYCLES + TEST_CYCLES + 10) * 12 / 10;

   typedef struct packed {
      logic [3:0] test;
      apb_addr_t  addr;
      apb_data_t  got;
      apb_data_t  exp;
   } data_item_t;

   typedef struct packed {
      logic [3:0] test;
      apb_addr_t  addr;
      logic       got;
      logic       exp;
   } err_item_t;

   typedef struct packed {
      logic [3:0] test;
      logic       chan;
      count_t     got;
      count_t     exp;
   } period_item_t;

   logic     hclk;
   logic     rst;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   logic     irq_lo;
   logic     irq_hi;

   int unsigned  cycle_cnt = 0;
   logic [31:0]  lcg_state = 32'he1ef_9fd7;
   int unsigned  irq_times [NUM_CHAN][$];  // cycle of every interrupt pulse
   data_item_t   data_q[$];
   err_item_t    err_q[$];
   period_item_t period_q[$];

   timer_unit u_timer_unit (
      .hclk_i    (hclk),
      .rst_i     (rst),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp),
      .irq_lo_o  (irq_lo),
      .irq_hi_o  (irq_hi)
   );

   initial begin
      hclk = 1'b0;
      forever #(CLK_PERIOD / 2) hclk = ~hclk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // reference model for CFG readback and interrupt spacing
   function automatic apb_data_t expected_cfg(apb_data_t written);
      apb_data_t mask;
      mask = '0;
      mask[CFG_EN_BIT]               = 1'b1;
      mask[CFG_ONE_SHOT_BIT]         = 1'b1;
      mask[CFG_PRESC_EN_BIT]         = 1'b1;
      mask[CFG_PRESC_LSB +: PRESC_W] = '1;
      return written & mask;
   endfunction

   function automatic count_t expected_period(count_t cmp, logic presc_en, presc_t presc);
      count_t divide;
      divide = presc_en ? count_t'(presc) + 1 : 1;
      return (cmp + 1) * divide;
   endfunction

   function automatic apb_addr_t reg_addr(int chan, reg_offs_t offs);
      return apb_addr_t'(chan * CHAN_STRIDE + offs);
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("FAILED t=%0t %s: got 0x%08h, expected 0x%08h",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("FAILED t=%0t %s: pslverr %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_period(input count_t got, input count_t exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("FAILED t=%0t %s: %0d cycles, expected %0d",
                             $time, what, got, exp));
      end
   endtask

   // one zero-wait transfer that returns the cycle of its access phase
   task automatic bus_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                               output apb_data_t rdata, output logic err,
                               output int unsigned acc_cycle);
      @(posedge hclk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= write;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge hclk);
      apb_req.penable <= 1'b1;
      @(negedge hclk);
      rdata     = apb_rsp.prdata;
      err       = apb_rsp.pslverr;
      acc_cycle = cycle_cnt;
      @(posedge hclk);
      apb_req <= '0;
   endtask

   task automatic write_reg(input logic [3:0] test, input apb_addr_t addr, input apb_data_t data,
                            input logic exp_err, output int unsigned acc_cycle);
      apb_data_t rdata;
      logic      err;
      bus_transfer(1'b1, addr, data, rdata, err, acc_cycle);
      err_q.push_back(err_item_t'({test, addr, err, exp_err}));
   endtask

   task automatic read_reg(input logic [3:0] test, input apb_addr_t addr,
                           input apb_data_t exp_data, input logic exp_err);
      apb_data_t   rdata;
      logic        err;
      int unsigned acc_cycle;
      bus_transfer(1'b0, addr, '0, rdata, err, acc_cycle);
      data_q.push_back(data_item_t'({test, addr, rdata, exp_data}));
      err_q.push_back(err_item_t'({test, addr, err, exp_err}));
   endtask

   task automatic queue_period(input logic [3:0] test, input int chan, input count_t got,
                               input count_t exp);
      period_q.push_back(period_item_t'({test, 1'(chan), got, exp}));
   endtask

   task automatic wait_pulses(input int chan, input int unsigned n, input int unsigned limit);
      int unsigned waited;
      waited = 0;
      while (irq_times[chan].size() < n) begin
         if (waited == limit) begin
            abort_run($sformatf("%s channel interrupt never arrived within %0d cycles",
                                (chan == CHAN_HI) ? "hi" : "lo", limit));
         end
         @(posedge hclk);
         waited++;
      end
   endtask

   task automatic clear_pulses();
      irq_times[CHAN_LO].delete();
      irq_times[CHAN_HI].delete();
   endtask

   task automatic drop_pulses_until(input int chan, input int unsigned cycle);
      while (irq_times[chan].size() > 0 && irq_times[chan][0] <= cycle) begin
         void'(irq_times[chan].pop_front());
      end
   endtask

   always @(posedge hclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         abort_run($sformatf("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES));
      end
   end

   always @(negedge hclk) begin  // irq is stable mid cycle
      if (irq_lo) irq_times[CHAN_LO].push_back(cycle_cnt);
      if (irq_hi) irq_times[CHAN_HI].push_back(cycle_cnt);
   end

   always @(negedge hclk) begin
      if (u_timer_unit.u_timer_unit_assert.fail_count != 0) begin
         abort_run("a bus or interrupt assertion on the timer failed");
      end
   end

   initial begin : compare_results
      data_item_t   d;
      err_item_t    e;
      period_item_t p;
      forever begin
         @(posedge hclk);
         while (data_q.size() > 0) begin
            d = data_q.pop_front();
            check_data(d.got, d.exp, $sformatf("test %0d read of 0x%03h", d.test, d.addr));
         end
         while (err_q.size() > 0) begin
            e = err_q.pop_front();
            check_err(e.got, e.exp, $sformatf("test %0d access to 0x%03h", e.test, e.addr));
         end
         while (period_q.size() > 0) begin
            p = period_q.pop_front();
            check_period(p.got, p.exp, $sformatf("test %0d irq spacing on channel %0d",
                                                 p.test, p.chan));
         end
      end
   end

   initial begin : run_tests
      apb_data_t   cfg_word;
      apb_data_t   en_bit;
      apb_data_t   shot_bit;
      apb_data_t   pen_bit;
      apb_data_t   rst_bit;
      apb_data_t   cfg_shadow [NUM_CHAN];
      apb_data_t   cmp_shadow [NUM_CHAN];
      apb_data_t   cnt_shadow [NUM_CHAN];
      apb_addr_t   unmapped [5];
      count_t      cmp;
      count_t      period;
      presc_t      presc;
      int unsigned acc;

      rst      = 1'b1;
      apb_req  = '0;
      en_bit   = apb_data_t'(1) << CFG_EN_BIT;
      shot_bit = apb_data_t'(1) << CFG_ONE_SHOT_BIT;
      pen_bit  = apb_data_t'(1) << CFG_PRESC_EN_BIT;
      rst_bit  = apb_data_t'(1) << CFG_RESET_BIT;
      repeat (RESET_CYCLES) @(posedge hclk);
      rst <= 1'b0;

      // test 1 reads registers back with both channels disabled
      for (int c = 0; c < NUM_CHAN; c++) begin
         cfg_word      = next_random() & ~(en_bit | rst_bit);
         cfg_shadow[c] = expected_cfg(cfg_word);
         cmp_shadow[c] = next_random();
         cnt_shadow[c] = next_random();
         write_reg(4'd1, reg_addr(c, REG_CFG), cfg_word, 1'b0, acc);
         write_reg(4'd1, reg_addr(c, REG_CMP), cmp_shadow[c], 1'b0, acc);
         write_reg(4'd1, reg_addr(c, REG_CNT), cnt_shadow[c], 1'b0, acc);
         read_reg(4'd1, reg_addr(c, REG_CFG), cfg_shadow[c], 1'b0);
         read_reg(4'd1, reg_addr(c, REG_CMP), cmp_shadow[c], 1'b0);
         read_reg(4'd1, reg_addr(c, REG_CNT), cnt_shadow[c], 1'b0);
      end

      // test 2 hits unmapped offsets and then rereads every register
      unmapped[0] = 'h00C;
      unmapped[1] = 'h01C;
      unmapped[2] = 'h020;
      unmapped[3] = 'h7F8;
      unmapped[4] = 'h002;
      foreach (unmapped[i]) begin
         write_reg(4'd2, unmapped[i], next_random(), 1'b1, acc);
         read_reg(4'd2, unmapped[i], '0, 1'b1);
      end
      for (int c = 0; c < NUM_CHAN; c++) begin
         read_reg(4'd2, reg_addr(c, REG_CFG), cfg_shadow[c], 1'b0);
         read_reg(4'd2, reg_addr(c, REG_CMP), cmp_shadow[c], 1'b0);
         read_reg(4'd2, reg_addr(c, REG_CNT), cnt_shadow[c], 1'b0);
      end

      // test 3 runs lo in continuous mode through the prescaler
      presc    = presc_t'(next_random() % 8);
      cmp      = count_t'(1 + next_random() % 8);
      period   = expected_period(cmp, 1'b1, presc);
      cfg_word = en_bit | pen_bit | (apb_data_t'(presc) << CFG_PRESC_LSB);
      clear_pulses();
      write_reg(4'd3, reg_addr(CHAN_LO, REG_CMP), cmp, 1'b0, acc);
      write_reg(4'd3, reg_addr(CHAN_LO, REG_CNT), '0, 1'b0, acc);
      write_reg(4'd3, reg_addr(CHAN_LO, REG_CFG), cfg_word, 1'b0, acc);
      wait_pulses(CHAN_LO, 3, 3 * period + 4);
      queue_period(4'd3, CHAN_LO, count_t'(irq_times[CHAN_LO][0] - acc), period);
      for (int i = 1; i < 3; i++) begin
         queue_period(4'd3, CHAN_LO, count_t'(irq_times[CHAN_LO][i] - irq_times[CHAN_LO][i-1]),
                      period);
      end
      if (irq_times[CHAN_HI].size() != 0) begin
         abort_run("hi channel raised an interrupt while it was disabled");
      end
      write_reg(4'd3, reg_addr(CHAN_LO, REG_CFG), '0, 1'b0, acc);

      // test 4 runs hi one-shot with the prescaler bypassed
      cmp      = count_t'(1 + next_random() % 15);
      period   = expected_period(cmp, 1'b0, '0);
      cfg_word = en_bit | shot_bit;
      clear_pulses();
      write_reg(4'd4, reg_addr(CHAN_HI, REG_CMP), cmp, 1'b0, acc);
      write_reg(4'd4, reg_addr(CHAN_HI, REG_CNT), '0, 1'b0, acc);
      write_reg(4'd4, reg_addr(CHAN_HI, REG_CFG), cfg_word, 1'b0, acc);
      wait_pulses(CHAN_HI, 1, period + 4);
      queue_period(4'd4, CHAN_HI, count_t'(irq_times[CHAN_HI][0] - acc), period);
      repeat (2 * period) @(posedge hclk);
      if (irq_times[CHAN_HI].size() != 1) begin
         abort_run("one-shot channel raised more than one interrupt");
      end
      read_reg(4'd4, reg_addr(CHAN_HI, REG_CFG), expected_cfg(cfg_word & ~en_bit), 1'b0);
      read_reg(4'd4, reg_addr(CHAN_HI, REG_CNT), '0, 1'b0);

      // test 5 resets the lo count in the middle of a period
      presc    = presc_t'(2 + next_random() % 6);  // divide of 3 or more keeps CNT at 0
      cmp      = count_t'(1 + next_random() % 8);
      period   = expected_period(cmp, 1'b1, presc);
      cfg_word = en_bit | pen_bit | (apb_data_t'(presc) << CFG_PRESC_LSB);
      clear_pulses();
      write_reg(4'd5, reg_addr(CHAN_LO, REG_CMP), cmp, 1'b0, acc);
      write_reg(4'd5, reg_addr(CHAN_LO, REG_CNT), '0, 1'b0, acc);
      write_reg(4'd5, reg_addr(CHAN_LO, REG_CFG), cfg_word, 1'b0, acc);
      wait_pulses(CHAN_LO, 1, period + 4);
      repeat (1 + next_random() % period) @(posedge hclk);
      write_reg(4'd5, reg_addr(CHAN_LO, REG_CFG), cfg_word | rst_bit, 1'b0, acc);
      drop_pulses_until(CHAN_LO, acc);
      read_reg(4'd5, reg_addr(CHAN_LO, REG_CNT), '0, 1'b0);
      wait_pulses(CHAN_LO, 1, period + 4);
      queue_period(4'd5, CHAN_LO, count_t'(irq_times[CHAN_LO][0] - acc), period);
      read_reg(4'd5, reg_addr(CHAN_LO, REG_CFG), expected_cfg(cfg_word | rst_bit), 1'b0);
      write_reg(4'd5, reg_addr(CHAN_LO, REG_CFG), '0, 1'b0, acc);

      while (data_q.size() > 0 || err_q.size() > 0 || period_q.size() > 0) begin
         @(posedge hclk);
      end
      @(posedge hclk);
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
src/apb_pkg.sv
src/timer_pkg.sv
src/timer_prescaler.sv
src/timer_counter.sv
src/timer_regs.sv
src/timer_unit.sv
verification/timer_unit_assert.sv
verification/tb_timer_unit.sv

//--- Bender.yml
package:
  name: timer_unit

sources:
  - src/apb_pkg.sv
  - src/timer_pkg.sv
  - src/timer_prescaler.sv
  - src/timer_counter.sv
  - src/timer_regs.sv
  - src/timer_unit.sv
  - target: test
    files:
      - verification/timer_unit_assert.sv
      - verification/tb_timer_unit.sv
